/* files.f */
common/regfile_pkg.sv
source/gpr_file.sv
source/mmx_file.sv
source/regfile.sv
sim/regfile_sva.sv
sim/regfile_tb.sv

/* Makefile */
# Verilator build and run for the register file testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= regfile_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "RESULT: FAIL (run ended early)"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/regfile_tb.sv */
`timescale 1ns/1ps

module regfile_tb
    import regfile_pkg::*;
;

    logic         clk;
    logic         arst_n;
    logic         clr;
    wr_bus_t      wr;
    access_size_e wr_size;
    rd_addr_t     rd_addr;
    access_size_e rd_size;
    rd_data_t     rd_data;

    wr_bus_t      next_wr;            // ports staged for the next commit
    logic [31:0]  gpr_m [NUM_REGS];   // model of the gpr bank
    logic [63:0]  mmx_m [NUM_REGS];   // model of the mmx bank
    integer       seed;
    int           mismatches;
    int           other_errs;
    logic [31:0]  rnd;
    access_size_e sz_list [4];

    regfile regfile_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .clr     (clr),
        .wr      (wr),
        .wr_size (wr_size),
        .rd_addr (rd_addr),
        .rd_size (rd_size),
        .rd_data (rd_data)
    );

    always #20 clk = ~clk;

    initial begin
        #2_000_000;
        $display("timeout: the run did not reach its end in time");
        $display("Test failures found");
        $finish;
    end

    function automatic logic [63:0] rand64();
        rand64 = {$random(seed), $random(seed)};
    endfunction

    // expected lane where AH..BH alias regs 0-3
    function automatic logic [63:0] expect_lane(input access_size_e sz, input logic [2:0] a);
        logic [31:0] g;
        g = gpr_m[{1'b0, a[1:0]}];
        case (sz)
            SZ_8:    expect_lane = a[2] ? {56'd0, g[15:8]} : {56'd0, g[7:0]};
            SZ_16:   expect_lane = {48'd0, gpr_m[a][15:0]};
            SZ_32:   expect_lane = {32'd0, gpr_m[a]};
            SZ_MMX:  expect_lane = mmx_m[a];
            default: expect_lane = 64'd0;
        endcase
    endfunction

    task automatic put_port(input int p, input int a, input logic [63:0] d);
        next_wr[p].en   = 1'b1;
        next_wr[p].addr = REG_AW'(a);
        next_wr[p].data = d;
    endtask

    // one write cycle where the model walks ports in order so the last one wins
    task automatic commit(input access_size_e sz, input logic c);
        logic [2:0]  a;
        logic [63:0] d;
        wr      = next_wr;
        wr_size = sz;
        clr     = c;
        @(posedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            a = next_wr[p].addr;
            d = next_wr[p].data;
            if (next_wr[p].en && !c) begin
                case (sz)
                    SZ_8: begin
                        if (a[2]) begin
                            gpr_m[{1'b0, a[1:0]}][15:8] = d[7:0];
                        end else begin
                            gpr_m[{1'b0, a[1:0]}][7:0] = d[7:0];
                        end
                    end
                    SZ_16:   gpr_m[a][15:0] = d[15:0];
                    SZ_32:   gpr_m[a] = d[31:0];
                    SZ_MMX:  mmx_m[a] = d;
                    default: ;
                endcase
            end
        end
        if (c) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                gpr_m[r] = '0;
                mmx_m[r] = '0;
            end
        end
        @(negedge clk);
        wr      = '0;
        wr_size = SZ_NONE;
        clr     = 1'b0;
        next_wr = '0;
    endtask

    task automatic check_reads(input access_size_e sz, input rd_addr_t a);
        logic [63:0] exp;
        rd_size = sz;
        rd_addr = a;
        #5;
        for (int q = 0; q < NUM_PORTS; q++) begin
            exp = expect_lane(sz, a[q]);
            assert (rd_data[q] === exp) else begin
                mismatches++;
                $display("MISMATCH t=%0t rd_data[%0d] (%s, addr %0d) got=%h exp=%h",
                         $time, q, sz.name(), a[q], rd_data[q], exp);
            end
        end
        @(negedge clk);
    endtask

    task automatic check_all(input access_size_e sz);
        rd_addr_t a;
        for (int base = 0; base < NUM_REGS; base += NUM_PORTS) begin
            for (int q = 0; q < NUM_PORTS; q++) begin
                a[q] = REG_AW'(base + q);
            end
            check_reads(sz, a);
        end
    endtask

    task automatic wait_lanes_zero();
        int  n;
        logic done;
        n    = 0;
        done = 1'b0;
        rd_size = SZ_32;
        while (!done && n < 20) begin
            #5;
            if (rd_data == '0) begin
                done = 1'b1;
            end
            @(negedge clk);
            n++;
        end
        if (!done) begin
            other_errs++;
            $display("timeout: read lanes did not settle to zero after reset");
        end
    endtask

    initial begin
        seed       = 12272;
        mismatches = 0;
        other_errs = 0;
        sz_list    = '{SZ_8, SZ_16, SZ_32, SZ_MMX};
        clk        = 1'b0;
        arst_n     = 1'b0;
        clr        = 1'b0;
        wr         = '0;
        wr_size    = SZ_NONE;
        rd_addr    = '0;
        rd_size    = SZ_NONE;
        next_wr    = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            gpr_m[r] = '0;
            mmx_m[r] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        wait_lanes_zero();

        check_all(SZ_8); // reset state at every size
        check_all(SZ_16);
        check_all(SZ_32);
        check_all(SZ_MMX);
        check_all(SZ_NONE);

        for (int p = 0; p < NUM_PORTS; p++) put_port(p, 2 * p + 1, rand64());
        commit(SZ_32, 1'b0);
        check_reads(SZ_32, {3'd7, 3'd5, 3'd3, 3'd1});
        for (int p = 0; p < NUM_PORTS; p++) put_port(p, 2 * p, rand64());
        commit(SZ_32, 1'b0);
        check_all(SZ_32);

        put_port(1, 2, rand64()); // low byte of reg 2
        commit(SZ_8, 1'b0);
        check_all(SZ_8);
        check_all(SZ_32);
        put_port(3, 6, rand64()); // high byte of reg 2
        commit(SZ_8, 1'b0);
        check_all(SZ_8);
        check_all(SZ_16);
        put_port(2, 2, rand64());
        commit(SZ_16, 1'b0);
        check_all(SZ_16);
        check_all(SZ_32);

        for (int p = 0; p < NUM_PORTS; p++) put_port(p, p, rand64());
        commit(SZ_MMX, 1'b0);
        check_all(SZ_32);
        check_all(SZ_MMX);
        for (int p = 0; p < NUM_PORTS; p++) put_port(p, p + 4, rand64());
        commit(SZ_32, 1'b0);
        check_all(SZ_MMX);
        check_all(SZ_32);

        for (int p = 0; p < NUM_PORTS; p++) put_port(p, 5, rand64());
        commit(SZ_32, 1'b0);
        for (int p = 1; p < NUM_PORTS; p++) put_port(p, 6, rand64());
        commit(SZ_MMX, 1'b0);
        put_port(1, 4, rand64()); // both hit AH
        put_port(3, 4, rand64());
        commit(SZ_8, 1'b0);
        put_port(0, 3, rand64());
        put_port(2, 3, rand64());
        commit(SZ_16, 1'b0);
        check_all(SZ_8);
        check_all(SZ_32);
        check_all(SZ_MMX);
        check_all(SZ_NONE); // idle read with both banks loaded

        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (rnd[8 + p]) put_port(p, int'(rnd[4 * p +: 3]), rand64());
            end
            commit(sz_list[rnd[31:30]], 1'b0);
            check_all(sz_list[rnd[29:28]]);
        end

        for (int p = 0; p < NUM_PORTS; p++) put_port(p, p + 2, rand64());
        commit(SZ_32, 1'b1); // clear beats the writes
        check_all(SZ_8);
        check_all(SZ_32);
        check_all(SZ_MMX);
        for (int p = 0; p < NUM_PORTS; p++) put_port(p, p, rand64());
        commit(SZ_MMX, 1'b1);
        check_all(SZ_MMX);
        check_all(SZ_NONE);

        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errs);
        if (mismatches + other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim/regfile_sva.sv */
`timescale 1ns/1ps

module regfile_sva
    import regfile_pkg::*;
(
    input logic         clk,
    input logic         arst_n,
    input logic         clr,
    input access_size_e rd_size,
    input rd_data_t     rd_data
);

    // sampled before the first edge after release, so nothing written yet
    reset_zero: assert property (
        @(posedge clk) $rose(arst_n) |-> (rd_data == '0)
    ) else $error("read lanes not zero after reset release");

    clr_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        clr |=> (rd_data == '0)
    ) else $error("read lanes not zero in the cycle after clr");

    none_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rd_size == SZ_NONE) |-> (rd_data == '0)
    ) else $error("read lanes not zero for an idle read size");

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_lane
        gpr_zext: assert property (
            @(posedge clk) disable iff (!arst_n)
            (rd_size inside {SZ_8, SZ_16, SZ_32}) |-> (rd_data[g][63:32] == '0)
        ) else $error("lane %0d upper half not zero on a gpr read", g);
    end

endmodule

bind regfile regfile_sva regfile_sva_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .clr     (clr),
    .rd_size (rd_size),
    .rd_data (rd_data)
);

/* source/regfile.sv */
`timescale 1ns/1ps

module regfile
    import regfile_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         clr,
    input  wr_bus_t      wr,
    input  access_size_e wr_size,
    input  rd_addr_t     rd_addr,
    input  access_size_e rd_size,
    output rd_data_t     rd_data
);

    logic     wr_gpr;
    logic     wr_mmx;
    wr_bus_t  gpr_wr;
    wr_bus_t  mmx_wr;
    rd_data_t gpr_rd;
    rd_data_t mmx_rd;

    // which bank the writeback size addresses
    always_comb begin
        wr_gpr = 1'b0;
        wr_mmx = 1'b0;
        case (wr_size)
            SZ_8, SZ_16, SZ_32: wr_gpr = 1'b1;
            SZ_MMX:             wr_mmx = 1'b1;
            default: ;
        endcase
    end

    // payload goes to both banks, only the enables are split
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            gpr_wr[p]    = wr[p];
            mmx_wr[p]    = wr[p];
            gpr_wr[p].en = wr[p].en & wr_gpr;
            mmx_wr[p].en = wr[p].en & wr_mmx;
        end
    end

    gpr_file gpr_file_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .clr     (clr),
        .wr      (gpr_wr),
        .wr_size (wr_size),
        .rd_addr (rd_addr),
        .rd_size (rd_size),
        .rd_data (gpr_rd)
    );

    mmx_file mmx_file_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .clr     (clr),
        .wr      (mmx_wr),
        .rd_addr (rd_addr),
        .rd_data (mmx_rd)
    );

    // gpr lanes already come back zero for SZ_NONE
    always_comb begin
        for (int q = 0; q < NUM_PORTS; q++) begin
            if (rd_size == SZ_MMX) begin
                rd_data[q] = mmx_rd[q];
            end else begin
                rd_data[q] = gpr_rd[q];
            end
        end
    end

endmodule

/* source/mmx_file.sv */
`timescale 1ns/1ps

module mmx_file
    import regfile_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     clr,
    input  wr_bus_t  wr,
    input  rd_addr_t rd_addr,
    output rd_data_t rd_data
);

    logic [NUM_REGS-1:0][MMX_W-1:0] mm_q;
    logic [NUM_REGS-1:0][MMX_W-1:0] mm_d;
    logic [NUM_REGS-1:0]            mm_ld;

    // highest enabled port wins per register
    always_comb begin
        mm_ld = '0;
        mm_d  = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr[p].en) begin
                mm_ld[wr[p].addr] = 1'b1;
                mm_d[wr[p].addr]  = wr[p].data;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mm_q <= '0;
        end else if (clr) begin
            mm_q <= '0;
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (mm_ld[r]) begin
                    mm_q[r] <= mm_d[r];
                end
            end
        end
    end

    // full 64 bits, top level picks the lane
    always_comb begin
        for (int q = 0; q < NUM_PORTS; q++) begin
            rd_data[q] = mm_q[rd_addr[q]];
        end
    end

endmodule

/* source/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file
    import regfile_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         clr,
    input  wr_bus_t      wr,
    input  access_size_e wr_size,
    input  rd_addr_t     rd_addr,
    input  access_size_e rd_size,
    output rd_data_t     rd_data
);

    // each register split as ext:hi:lo, 16/8/8 bits
    logic [NUM_REGS-1:0][GPR_W-17:0] ext_q;
    logic [NUM_REGS-1:0][7:0]        hi_q;
    logic [NUM_REGS-1:0][7:0]        lo_q;

    logic [NUM_REGS-1:0]             ext_ld;
    logic [NUM_REGS-1:0]             hi_ld;
    logic [NUM_REGS-1:0]             lo_ld;
    logic [NUM_REGS-1:0][GPR_W-17:0] ext_d;
    logic [NUM_REGS-1:0][7:0]        hi_d;
    logic [NUM_REGS-1:0][7:0]        lo_d;

    // section load vector, later ports overwrite earlier ones
    always_comb begin
        logic [REG_AW-1:0] tgt;
        tgt    = '0;
        ext_ld = '0;
        hi_ld  = '0;
        lo_ld  = '0;
        ext_d  = '0;
        hi_d   = '0;
        lo_d   = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr[p].en) begin
                case (wr_size)
                    SZ_8: begin
                        tgt = {1'b0, wr[p].addr[1:0]}; // AH..BH alias regs 0-3
                        if (wr[p].addr[2]) begin
                            hi_ld[tgt] = 1'b1;
                            hi_d[tgt]  = wr[p].data[7:0];
                        end else begin
                            lo_ld[tgt] = 1'b1;
                            lo_d[tgt]  = wr[p].data[7:0];
                        end
                    end
                    SZ_16: begin
                        tgt        = wr[p].addr;
                        hi_ld[tgt] = 1'b1;
                        lo_ld[tgt] = 1'b1;
                        hi_d[tgt]  = wr[p].data[15:8];
                        lo_d[tgt]  = wr[p].data[7:0];
                    end
                    SZ_32: begin
                        tgt         = wr[p].addr;
                        ext_ld[tgt] = 1'b1;
                        hi_ld[tgt]  = 1'b1;
                        lo_ld[tgt]  = 1'b1;
                        ext_d[tgt]  = wr[p].data[GPR_W-1:16];
                        hi_d[tgt]   = wr[p].data[15:8];
                        lo_d[tgt]   = wr[p].data[7:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_q <= '0;
            hi_q  <= '0;
            lo_q  <= '0;
        end else if (clr) begin // clear beats any write
            ext_q <= '0;
            hi_q  <= '0;
            lo_q  <= '0;
        end else begin
            for (int r = 0; r < NUM_REGS; r++) begin
                if (ext_ld[r]) begin
                    ext_q[r] <= ext_d[r];
                end
                if (hi_ld[r]) begin
                    hi_q[r] <= hi_d[r];
                end
                if (lo_ld[r]) begin
                    lo_q[r] <= lo_d[r];
                end
            end
        end
    end

    // sized read, zero-extended to the lane
    always_comb begin
        logic [REG_AW-1:0] ra;
        logic [REG_AW-1:0] ba;
        ra = '0;
        ba = '0;
        for (int q = 0; q < NUM_PORTS; q++) begin
            ra = rd_addr[q];
            ba = {1'b0, ra[1:0]};
            case (rd_size)
                SZ_8: begin
                    if (ra[2]) begin
                        rd_data[q] = MMX_W'(hi_q[ba]);
                    end else begin
                        rd_data[q] = MMX_W'(lo_q[ba]);
                    end
                end
                SZ_16:   rd_data[q] = MMX_W'({hi_q[ra], lo_q[ra]});
                SZ_32:   rd_data[q] = MMX_W'({ext_q[ra], hi_q[ra], lo_q[ra]});
                default: rd_data[q] = '0; // idle or mmx
            endcase
        end
    end

endmodule

/* common/regfile_pkg.sv */
package regfile_pkg;

    localparam int NUM_PORTS = 4;  // read ports and write ports
    localparam int NUM_REGS  = 8;  // per bank
    localparam int REG_AW    = 3;
    localparam int GPR_W     = 32;
    localparam int MMX_W     = 64; // also the read lane width

    // one-hot style size code, bit 3 selects the MMX bank
    typedef enum logic [3:0] {
        SZ_NONE = 4'b0000,
        SZ_8    = 4'b0001,
        SZ_16   = 4'b0010,
        SZ_32   = 4'b0100,
        SZ_MMX  = 4'b1000
    } access_size_e;

    typedef struct packed {
        logic              en;
        logic [REG_AW-1:0] addr;
        logic [MMX_W-1:0]  data; // gpr writes take the low 32 bits
    } wr_port_t;

    typedef wr_port_t [NUM_PORTS-1:0] wr_bus_t;

    typedef logic [NUM_PORTS-1:0][REG_AW-1:0] rd_addr_t;

    typedef logic [NUM_PORTS-1:0][MMX_W-1:0] rd_data_t;

endpackage
